//--- decode_stage.f
+incdir+verif
common/decode_pkg.sv
decode/opcode_classifier.sv
decode/immediate_extender.sv
verilog/decode_buffer.sv
verilog/decode_stage.sv
verif/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module decode_stage_tb \
	-f decode_stage.f -o decode_stage_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/decode_stage_sim > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"
exit 0

//--- verif/decode_checks.svh
// ==================================================
// Compare tasks and reference model for the decode
// stage testbench. Included inside the testbench
// module, which supplies checks_done and abort_run.
// The model builds the expected decoded record from
// the instruction word alone.
// ==================================================

`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

typedef struct packed {
	logic  valid;
	addr_t ip;
	addr_t pip;
	logic  predict_taken;
	reg_t  ra;
	reg_t  rb;
	reg_t  rc;
	reg_t  rt;
	logic  rfwr;
	logic  need_rc;
	logic  branch;
	logic  mem_op;
	logic  unimpl;
	word_t imm;
} dec_rec_t;

task automatic check_reg(input string name, input reg_t got, input reg_t exp);
	checks_done++;
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
	checks_done++;
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
	checks_done++;
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	checks_done++;
	if (got !== exp) begin
		$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		abort_run();
	end
endtask

// Fields are cut from the raw bits rather than the union views
function automatic dec_rec_t expected_record(input logic v, input instr_t ins,
		input addr_t ip_in, input addr_t pip_in, input logic pt_in);
	dec_rec_t    r;
	logic [7:0]  op;
	logic [5:0]  fn;
	reg_t        rt_f;
	logic [15:0] imm16;
	logic [15:0] disp;
	logic        unary;
	logic        binary;
	logic        shift_imm;
	logic        chk;
	logic        alu_imm;
	logic        link;
	logic        cbr;
	logic        load;
	logic        store;
	logic        writes;
	op        = ins[7:0];
	fn        = ins[31:26];
	rt_f      = ins[13:8];
	imm16     = ins[35:20];
	disp      = {ins[35:26], ins[13:8]};
	unary     = (op == OP_R1) && (fn inside {FN_ABS, FN_NOT, FN_CTLZ, FN_CTPOP});
	shift_imm = (op == OP_R2) && (fn inside {FN_SLLI, FN_SRLI});
	binary    = shift_imm || ((op == OP_R2) && (fn inside {FN_ADD, FN_SUB, FN_AND,
		FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SLT, FN_SLTU, FN_CMP}));
	chk       = (op == OP_R3) && (fn == FN_CHK);
	alu_imm   = op inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTUI};
	link      = op inside {OP_JAL, OP_JALR};
	cbr       = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE};
	load      = (op == OP_LDX);
	store     = (op == OP_STX);
	writes    = unary | binary | alu_imm | link | load;

	r.valid         = v;
	r.ip            = ip_in;
	r.pip           = pip_in;
	r.predict_taken = pt_in;
	r.ra            = ins[19:14];
	r.rb            = ins[25:20];
	r.rc            = chk ? rt_f : '0;
	if (link)
		r.rt = {4'b0000, rt_f[1:0]};
	else if (writes)
		r.rt = rt_f;
	else
		r.rt = '0;
	r.rfwr    = v & writes;
	r.need_rc = v & chk;
	r.branch  = v & cbr;
	r.mem_op  = v & (op[7:5] == 3'b011);
	r.unimpl  = !(writes | chk | cbr | store);

	if (shift_imm)
		r.imm = {58'd0, ins[25:20]};
	else if (cbr | store)
		r.imm = {{48{disp[15]}}, disp};
	else if (op == OP_ANDI)
		r.imm = {48'hFFFF_FFFF_FFFF, imm16};
	else if (op inside {OP_ORI, OP_XORI, OP_SLTUI})
		r.imm = {48'd0, imm16};
	else if (op inside {OP_ADDI, OP_SLTI, OP_LDX, OP_JAL, OP_JALR})
		r.imm = {{48{imm16[15]}}, imm16};
	else
		r.imm = '0;
	return r;
endfunction

`endif

//--- verif/decode_stage_tb.sv
// ==================================================
// Testbench for the decode stage
// Drives directed and random instructions on falling
// edges and compares every decoded field one cycle
// later against the reference model in the header.
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb
	import decode_pkg::*;
();

	// Cycles per test: reset, register ops, immediates, branches, memory, unimpl, burst
	localparam int TEST_CYCLES = 7 + 17 + 13 + 7 + 3 + 4 + 20;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 10) * 100;

	logic   clk;
	logic   reset;
	logic   valid;
	instr_t instr;
	addr_t  ip;
	addr_t  predicted_ip;
	logic   predict_taken;
	logic   dec_valid;
	addr_t  dec_ip;
	addr_t  dec_pip;
	logic   dec_predict_taken;
	reg_t   dec_ra;
	reg_t   dec_rb;
	reg_t   dec_rc;
	reg_t   dec_rt;
	logic   dec_rfwr;
	logic   dec_need_rc;
	logic   dec_branch;
	logic   dec_mem_op;
	logic   dec_unimpl;
	word_t  dec_imm;
	int     checks_done;

	logic [5:0] r1_fns [4]  = '{FN_ABS, FN_NOT, FN_CTLZ, FN_CTPOP};
	logic [5:0] r2_fns [12] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL,
		FN_SLLI, FN_SRLI, FN_SLT, FN_SLTU, FN_CMP};
	logic [7:0] alu_ops [6] = '{OP_ADDI, OP_SLTI, OP_ORI, OP_XORI, OP_SLTUI, OP_ANDI};
	logic [7:0] br_ops [4]  = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE};

	decode_stage dut0 (
		.clk (clk), .reset (reset), .valid (valid), .instr (instr), .ip (ip),
		.predicted_ip (predicted_ip), .predict_taken (predict_taken),
		.dec_valid (dec_valid), .dec_ip (dec_ip), .dec_pip (dec_pip),
		.dec_predict_taken (dec_predict_taken), .dec_ra (dec_ra), .dec_rb (dec_rb),
		.dec_rc (dec_rc), .dec_rt (dec_rt), .dec_rfwr (dec_rfwr),
		.dec_need_rc (dec_need_rc), .dec_branch (dec_branch), .dec_mem_op (dec_mem_op),
		.dec_unimpl (dec_unimpl), .dec_imm (dec_imm)
	);

	always #50 clk = ~clk;

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped on error");
	endtask

	`include "decode_checks.svh"

	// ==================================================
	// Stimulus helpers
	// ==================================================

	function automatic instr_t random_word();
		return {4'($urandom), $urandom};
	endfunction

	function automatic instr_t make_r(input logic [7:0] op, input logic [5:0] fn);
		return {4'($urandom), fn, 6'($urandom), 6'($urandom), 6'($urandom), op};
	endfunction

	function automatic instr_t make_ri(input logic [7:0] op, input logic [15:0] imm16);
		return {imm16, 12'($urandom), op};
	endfunction

	function automatic instr_t make_br(input logic [7:0] op, input logic [15:0] disp);
		return {disp[15:6], 12'($urandom), disp[5:0], op};
	endfunction

	function automatic instr_t random_kept();
		instr_t w;
		case ($urandom_range(6, 0))
		0: w = make_r(OP_R1, r1_fns[2'($urandom_range(3, 0))]);
		1: w = make_r(OP_R2, r2_fns[4'($urandom_range(11, 0))]);
		2: w = make_r(OP_R3, FN_CHK);
		3: w = make_ri(alu_ops[3'($urandom_range(5, 0))], 16'($urandom));
		4: w = make_ri($urandom_range(1, 0) == 0 ? OP_JAL : OP_JALR, 16'($urandom));
		5: w = make_br(br_ops[2'($urandom_range(3, 0))], 16'($urandom));
		default: w = $urandom_range(1, 0) == 0 ? make_ri(OP_LDX, 16'($urandom))
			: make_br(OP_STX, 16'($urandom));
		endcase
		return w;
	endfunction

	task automatic check_outputs(input dec_rec_t e);
		check_bit("dec_valid", dec_valid, e.valid);
		check_bit("dec_rfwr", dec_rfwr, e.rfwr);
		check_bit("dec_need_rc", dec_need_rc, e.need_rc);
		check_bit("dec_branch", dec_branch, e.branch);
		check_bit("dec_mem_op", dec_mem_op, e.mem_op);
		if (e.valid) begin
			check_addr("dec_ip", dec_ip, e.ip);
			check_addr("dec_pip", dec_pip, e.pip);
			check_bit("dec_predict_taken", dec_predict_taken, e.predict_taken);
			check_reg("dec_ra", dec_ra, e.ra);
			check_reg("dec_rb", dec_rb, e.rb);
			check_reg("dec_rc", dec_rc, e.rc);
			check_reg("dec_rt", dec_rt, e.rt);
			check_bit("dec_unimpl", dec_unimpl, e.unimpl);
			check_word("dec_imm", dec_imm, e.imm);
		end
	endtask

	// Called on a falling edge, returns on the next one with the record checked
	task automatic issue(input logic v, input instr_t ins);
		dec_rec_t exp;
		valid         = v;
		instr         = ins;
		ip            = $urandom;
		predicted_ip  = $urandom;
		predict_taken = 1'($urandom);
		exp = expected_record(v, ins, ip, predicted_ip, predict_taken);
		@(negedge clk);
		check_outputs(exp);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset();
		valid = 1'b1;
		repeat (3) begin
			instr = random_word();
			@(negedge clk);
			check_outputs(expected_record(1'b0, instr, ip, predicted_ip, 1'b0));
		end
		reset = 1'b0;
		// Each of these would raise one control flag if it were valid
		issue(1'b0, make_r(OP_R2, FN_ADD));
		issue(1'b0, make_r(OP_R3, FN_CHK));
		issue(1'b0, make_br(OP_BEQ, 16'($urandom)));
		issue(1'b0, make_ri(OP_LDX, 16'($urandom)));
	endtask

	task automatic test_reg_ops();
		instr_t ins;
		foreach (r1_fns[i]) issue(1'b1, make_r(OP_R1, r1_fns[i]));
		foreach (r2_fns[i]) issue(1'b1, make_r(OP_R2, r2_fns[i]));
		ins = make_r(OP_R2, FN_SLLI);
		ins.r2.rb = 6'h3F;
		issue(1'b1, ins);
		check_word("dec_imm", dec_imm, 64'h0000_0000_0000_003F);
	endtask

	task automatic test_immediates();
		foreach (alu_ops[i]) begin
			issue(1'b1, make_ri(alu_ops[i], 16'($urandom) | 16'h8000));
			issue(1'b1, make_ri(alu_ops[i], 16'($urandom) & 16'h7FFF));
		end
		issue(1'b1, make_ri(OP_ANDI, 16'h0F0F));
		check_word("dec_imm", dec_imm, 64'hFFFF_FFFF_FFFF_0F0F);
	endtask

	task automatic test_branches();
		foreach (br_ops[i]) issue(1'b1, make_br(br_ops[i], 16'($urandom)));
		issue(1'b1, make_br(OP_BNE, 16'h8001));
		check_word("dec_imm", dec_imm, 64'hFFFF_FFFF_FFFF_8001);
		issue(1'b1, make_ri(OP_JAL, 16'($urandom)));
		issue(1'b1, make_ri(OP_JALR, 16'($urandom)));
	endtask

	task automatic test_memory();
		issue(1'b1, make_ri(OP_LDX, 16'($urandom)));
		issue(1'b1, make_br(OP_STX, 16'($urandom)));
		check_reg("dec_rt", dec_rt, 6'h00);
		issue(1'b1, make_r(OP_R3, FN_CHK));
	endtask

	task automatic test_unimpl();
		instr_t odd [4];
		odd[0] = make_r(OP_BRK, 6'($urandom));
		odd[1] = make_r(OP_NOP, 6'($urandom));
		odd[2] = make_r(8'h20, 6'($urandom));
		odd[3] = make_r(OP_R2, 6'h3F);
		foreach (odd[i]) begin
			issue(1'b1, odd[i]);
			check_bit("dec_unimpl", dec_unimpl, 1'b1);
		end
	endtask

	task automatic test_back_to_back();
		repeat (20) issue(1'b1, random_kept());
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the decode stage tests did not complete in time");
		abort_run();
	end

	initial begin
		clk           = 1'b0;
		reset         = 1'b1;
		valid         = 1'b0;
		instr         = '0;
		ip            = '0;
		predicted_ip  = '0;
		predict_taken = 1'b0;
		checks_done   = 0;
		void'($urandom(32'h6ceb));
		test_reset();
		test_reg_ops();
		test_immediates();
		test_branches();
		test_memory();
		test_unimpl();
		test_back_to_back();
		if (checks_done > 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("No checks were run");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
// ==================================================
// Decode stage top level
// Feeds one instruction per cycle through the opcode
// classifier and immediate extender into the decode
// buffer. Latency is one cycle and it never stalls.
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module decode_stage
	import decode_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   valid,
	input  instr_t instr,
	input  addr_t  ip,
	input  addr_t  predicted_ip,
	input  logic   predict_taken,
	output logic   dec_valid,
	output addr_t  dec_ip,
	output addr_t  dec_pip,
	output logic   dec_predict_taken,
	output reg_t   dec_ra,
	output reg_t   dec_rb,
	output reg_t   dec_rc,
	output reg_t   dec_rt,
	output logic   dec_rfwr,
	output logic   dec_need_rc,
	output logic   dec_branch,
	output logic   dec_mem_op,
	output logic   dec_unimpl,
	output word_t  dec_imm
);

	reg_t       ra;
	reg_t       rb;
	reg_t       rc;
	reg_t       rt;
	logic       rfwr;
	logic       need_rc;
	logic       branch;
	logic       mem_op;
	logic       unimpl;
	logic [2:0] imm_kind;
	word_t      imm;

	opcode_classifier u_classifier (
		.instr    (instr),
		.ra       (ra),
		.rb       (rb),
		.rc       (rc),
		.rt       (rt),
		.rfwr     (rfwr),
		.need_rc  (need_rc),
		.branch   (branch),
		.mem_op   (mem_op),
		.unimpl   (unimpl),
		.imm_kind (imm_kind)
	);

	immediate_extender u_extender (
		.instr    (instr),
		.imm_kind (imm_kind),
		.imm      (imm)
	);

	decode_buffer u_buffer (
		.clk               (clk),
		.reset             (reset),
		.valid             (valid),
		.ip                (ip),
		.predicted_ip      (predicted_ip),
		.predict_taken     (predict_taken),
		.ra                (ra),
		.rb                (rb),
		.rc                (rc),
		.rt                (rt),
		.rfwr              (rfwr),
		.need_rc           (need_rc),
		.branch            (branch),
		.mem_op            (mem_op),
		.unimpl            (unimpl),
		.imm               (imm),
		.dec_valid         (dec_valid),
		.dec_ip            (dec_ip),
		.dec_pip           (dec_pip),
		.dec_predict_taken (dec_predict_taken),
		.dec_ra            (dec_ra),
		.dec_rb            (dec_rb),
		.dec_rc            (dec_rc),
		.dec_rt            (dec_rt),
		.dec_rfwr          (dec_rfwr),
		.dec_need_rc       (dec_need_rc),
		.dec_branch        (dec_branch),
		.dec_mem_op        (dec_mem_op),
		.dec_unimpl        (dec_unimpl),
		.dec_imm           (dec_imm)
	);

endmodule

`default_nettype wire

//--- verilog/decode_buffer.sv
// ==================================================
// Decode buffer, the output register of the stage
// Captures the decoded record once per cycle. The
// control flags are cleared on reset and whenever the
// incoming strobe is low; the payload just follows.
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module decode_buffer
	import decode_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  valid,
	input  addr_t ip,
	input  addr_t predicted_ip,
	input  logic  predict_taken,
	input  reg_t  ra,
	input  reg_t  rb,
	input  reg_t  rc,
	input  reg_t  rt,
	input  logic  rfwr,
	input  logic  need_rc,
	input  logic  branch,
	input  logic  mem_op,
	input  logic  unimpl,
	input  word_t imm,
	output logic  dec_valid,
	output addr_t dec_ip,
	output addr_t dec_pip,
	output logic  dec_predict_taken,
	output reg_t  dec_ra,
	output reg_t  dec_rb,
	output reg_t  dec_rc,
	output reg_t  dec_rt,
	output logic  dec_rfwr,
	output logic  dec_need_rc,
	output logic  dec_branch,
	output logic  dec_mem_op,
	output logic  dec_unimpl,
	output word_t dec_imm
);

	// ==================================================
	// Control flags
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid   <= 1'b0;
			dec_rfwr    <= 1'b0;
			dec_need_rc <= 1'b0;
			dec_branch  <= 1'b0;
			dec_mem_op  <= 1'b0;
		end else begin
			dec_valid   <= valid;
			dec_rfwr    <= valid & rfwr;
			dec_need_rc <= valid & need_rc;
			dec_branch  <= valid & branch;
			dec_mem_op  <= valid & mem_op;
		end
	end

	// Payload is don't-care while dec_valid is low
	always_ff @(posedge clk) begin
		dec_ip            <= ip;
		dec_pip           <= predicted_ip;
		dec_predict_taken <= predict_taken;
		dec_ra            <= ra;
		dec_rb            <= rb;
		dec_rc            <= rc;
		dec_rt            <= rt;
		dec_unimpl        <= unimpl;
		dec_imm           <= imm;
	end

	// ==================================================
	// Record consistency
	// ==================================================

	// A register write is only ever granted to a decoded instruction
	a_write_is_impl: assert property (@(posedge clk) disable iff (reset)
		dec_valid && dec_rfwr |-> !dec_unimpl)
		else $error("decode_buffer: write flagged on unimplemented instruction");

	a_branch_not_mem: assert property (@(posedge clk) disable iff (reset)
		!(dec_branch && dec_mem_op))
		else $error("decode_buffer: branch and memory flags both set");

	// CHK uses the write port for reading Rc
	a_rc_no_write: assert property (@(posedge clk) disable iff (reset)
		dec_need_rc |-> !dec_rfwr)
		else $error("decode_buffer: need_rc together with rfwr");

endmodule

`default_nettype wire

//--- decode/immediate_extender.sv
// ==================================================
// Immediate extender of the decode stage
// Combinational. Builds the 64-bit immediate from the
// instruction word in the form picked by the opcode
// classifier through imm_kind.
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module immediate_extender
	import decode_pkg::*;
(
	input  instr_t     instr,
	input  logic [2:0] imm_kind,
	output word_t      imm
);

	logic [15:0] imm16;
	logic [15:0] disp16;

	assign imm16 = instr.ri.imm16;

	// Branch and store displacement is split around the rt slot
	assign disp16 = {instr.br.disphi, instr.br.displo};

	always_comb begin
		case (imm_kind)
		IMM_SEXT16: begin
			imm = {{(WORD_W-16){imm16[15]}}, imm16};
		end
		IMM_ZEXT16: begin
			imm = {{(WORD_W-16){1'b0}}, imm16};
		end
		// ANDI keeps the upper bits of the source untouched
		IMM_ONES16: begin
			imm = {{(WORD_W-16){1'b1}}, imm16};
		end
		IMM_SHAMT: begin
			imm = {{(WORD_W-REG_W){1'b0}}, instr.r2.rb};
		end
		IMM_BRDISP: begin
			imm = {{(WORD_W-16){disp16[15]}}, disp16};
		end
		default: begin
			imm = '0;
		end
		endcase
	end

endmodule

`default_nettype wire

//--- decode/opcode_classifier.sv
// ==================================================
// Opcode classifier of the decode stage
// Purely combinational. Turns the opcode and function
// fields into register selects, control flags and the
// immediate kind used by the immediate extender.
// ==================================================

`timescale 1ns/1ps
`default_nettype none

module opcode_classifier
	import decode_pkg::*;
(
	input  instr_t     instr,
	output reg_t       ra,
	output reg_t       rb,
	output reg_t       rc,
	output reg_t       rt,
	output logic       rfwr,
	output logic       need_rc,
	output logic       branch,
	output logic       mem_op,
	output logic       unimpl,
	output logic [2:0] imm_kind
);

	reg_t rt_field;

	assign rt_field = instr.r2.rt;

	// Source selects are taken straight from the fields
	assign ra = instr.r2.ra;
	assign rb = instr.r2.rb;

	// The whole memory opcode block counts, listed or not
	assign mem_op = (instr.r2.opcode[7:5] == OP_LDX[7:5]);

	always_comb begin
		rc       = '0;
		rt       = '0;
		rfwr     = 1'b0;
		need_rc  = 1'b0;
		branch   = 1'b0;
		unimpl   = 1'b0;
		imm_kind = IMM_NONE;
		case (instr.r2.opcode)
		OP_BRK, OP_NOP: unimpl = 1'b1;
		OP_R1:
			case (instr.r2.func)
			FN_ABS, FN_NOT, FN_CTLZ, FN_CTPOP: begin
				rt   = rt_field;
				rfwr = 1'b1;
			end
			default: unimpl = 1'b1;
			endcase
		OP_R2:
			case (instr.r2.func)
			FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL,
			FN_SLT, FN_SLTU, FN_CMP: begin
				rt   = rt_field;
				rfwr = 1'b1;
			end
			// Shift amount comes from the rb field
			FN_SLLI, FN_SRLI: begin
				rt       = rt_field;
				rfwr     = 1'b1;
				imm_kind = IMM_SHAMT;
			end
			default: unimpl = 1'b1;
			endcase
		OP_R3:
			case (instr.r2.func)
			// CHK reads its bound through the rt field and writes nothing
			FN_CHK: begin
				rc      = rt_field;
				need_rc = 1'b1;
			end
			default: unimpl = 1'b1;
			endcase
		OP_ADDI, OP_SLTI, OP_LDX: begin
			rt       = rt_field;
			rfwr     = 1'b1;
			imm_kind = IMM_SEXT16;
		end
		OP_ORI, OP_XORI, OP_SLTUI: begin
			rt       = rt_field;
			rfwr     = 1'b1;
			imm_kind = IMM_ZEXT16;
		end
		OP_ANDI: begin
			rt       = rt_field;
			rfwr     = 1'b1;
			imm_kind = IMM_ONES16;
		end
		// Only four link registers exist
		OP_JAL, OP_JALR: begin
			rt       = {{(REG_W-2){1'b0}}, rt_field[1:0]};
			rfwr     = 1'b1;
			imm_kind = IMM_SEXT16;
		end
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE: begin
			branch   = 1'b1;
			imm_kind = IMM_BRDISP;
		end
		OP_STX: imm_kind = IMM_BRDISP;
		default: unimpl = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- common/decode_pkg.sv
// ==================================================
// Shared definitions for the instruction decode stage
// Holds the field widths, the opcode and function
// codes, the immediate-kind codes and the instruction
// word with its three field layouts. Modules take
// what they need by a wildcard import in the header.
// ==================================================

`default_nettype none

package decode_pkg;

	// ==================================================
	// Widths and scalar types
	// ==================================================

	localparam int INSTR_W = 36;
	localparam int REG_W   = 6;
	localparam int WORD_W  = 64;
	localparam int ADDR_W  = 32;

	typedef logic [REG_W-1:0]  reg_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// ==================================================
	// Opcodes
	// ==================================================

	localparam logic [7:0] OP_BRK   = 8'h00;
	localparam logic [7:0] OP_R1    = 8'h01;
	localparam logic [7:0] OP_R2    = 8'h02;
	localparam logic [7:0] OP_R3    = 8'h03;
	localparam logic [7:0] OP_ADDI  = 8'h04;
	localparam logic [7:0] OP_ANDI  = 8'h08;
	localparam logic [7:0] OP_ORI   = 8'h09;
	localparam logic [7:0] OP_XORI  = 8'h0A;
	localparam logic [7:0] OP_SLTI  = 8'h0C;
	localparam logic [7:0] OP_SLTUI = 8'h0D;
	localparam logic [7:0] OP_NOP   = 8'h3F;
	localparam logic [7:0] OP_JAL   = 8'h40;
	localparam logic [7:0] OP_JALR  = 8'h41;

	// Conditional branches live in 8'h48 to 8'h4F
	localparam logic [7:0] OP_BEQ   = 8'h48;
	localparam logic [7:0] OP_BNE   = 8'h49;
	localparam logic [7:0] OP_BLT   = 8'h4A;
	localparam logic [7:0] OP_BGE   = 8'h4B;

	// Memory ops fill 8'h60 to 8'h7F, so the top three opcode bits mark them
	localparam logic [7:0] OP_LDX   = 8'h60;
	localparam logic [7:0] OP_STX   = 8'h70;

	// ==================================================
	// Function codes
	// ==================================================

	// Unary ops under OP_R1
	localparam logic [5:0] FN_ABS   = 6'h00;
	localparam logic [5:0] FN_NOT   = 6'h02;
	localparam logic [5:0] FN_CTLZ  = 6'h08;
	localparam logic [5:0] FN_CTPOP = 6'h09;

	// Binary ops under OP_R2
	localparam logic [5:0] FN_ADD   = 6'h04;
	localparam logic [5:0] FN_SUB   = 6'h05;
	localparam logic [5:0] FN_AND   = 6'h08;
	localparam logic [5:0] FN_OR    = 6'h09;
	localparam logic [5:0] FN_XOR   = 6'h0A;
	localparam logic [5:0] FN_SLL   = 6'h10;
	localparam logic [5:0] FN_SRL   = 6'h11;
	localparam logic [5:0] FN_SLLI  = 6'h18;
	localparam logic [5:0] FN_SRLI  = 6'h19;
	localparam logic [5:0] FN_SLT   = 6'h20;
	localparam logic [5:0] FN_SLTU  = 6'h21;
	localparam logic [5:0] FN_CMP   = 6'h24;

	// Three-operand ops under OP_R3
	localparam logic [5:0] FN_CHK   = 6'h2A;

	// ==================================================
	// Immediate kinds
	// ==================================================

	localparam logic [2:0] IMM_NONE   = 3'd0;
	localparam logic [2:0] IMM_SEXT16 = 3'd1;
	localparam logic [2:0] IMM_ZEXT16 = 3'd2;
	localparam logic [2:0] IMM_ONES16 = 3'd3;
	localparam logic [2:0] IMM_SHAMT  = 3'd4;
	localparam logic [2:0] IMM_BRDISP = 3'd5;

	// ==================================================
	// Instruction word
	// ==================================================

	// Opcode, ra and rb sit at the same bits in every layout
	typedef union packed {
		struct packed {
			logic [INSTR_W-33:0] spare;
			logic [5:0]          func;
			reg_t                rb;
			reg_t                ra;
			reg_t                rt;
			logic [7:0]          opcode;
		} r2;
		struct packed {
			logic [15:0] imm16;
			reg_t        ra;
			reg_t        rt;
			logic [7:0]  opcode;
		} ri;
		struct packed {
			logic [9:0] disphi;
			reg_t       rb;
			reg_t       ra;
			logic [5:0] displo;
			logic [7:0] opcode;
		} br;
	} instr_t;

endpackage

`default_nettype wire
